// File: Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -sv --timescale 1ns/10ps
TOP = soc_bus_tb
FILELIST = sim.f
OBJ_DIR = obj_dir
# Let the testbench print its own verdict after an assertion error.
SIM_ARGS = +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// File: sim.f
source/bus_pkg.sv
source/bus_fabric.sv
source/data_ram.sv
source/timer_block.sv
source/irq_ctrl.sv
source/soc_bus_top.sv
verification/soc_bus_checker.sv
verification/soc_bus_tb.sv

// File: source/bus_fabric.sv
// Address decode and response merge for the data bus.
// Selects are combinational; the default responder answers one cycle after
// a strobed access that hits no window, with ack and error and zero data.
// Responders must drive all zeros when idle, since responses are ORed.
`timescale 1ns/10ps

module bus_fabric (
	input logic clk,
	input logic i_rst,
	input logic i_access,
	input bus_pkg::bus_req_t i_req,
	input bus_pkg::bus_rsp_t i_ram_rsp,
	input bus_pkg::bus_rsp_t i_timer_rsp,
	input bus_pkg::bus_rsp_t i_irq_rsp,
	output logic o_ram_cs,
	output logic o_timer_cs,
	output logic o_irq_cs,
	output bus_pkg::bus_rsp_t o_rsp
);

	logic any_cs;
	logic dflt_ack;
	logic dflt_error;
	bus_pkg::bus_rsp_t dflt_rsp;

	function automatic logic in_window(
		input bus_pkg::word_addr_t addr,
		input bus_pkg::word_addr_t base,
		input int unsigned words
	);
		in_window = (addr >= base) &&
			((addr - base) < bus_pkg::word_addr_t'(words));
	endfunction

	assign o_ram_cs = in_window(i_req.addr, bus_pkg::RAM_BASE, bus_pkg::RAM_WORDS);
	assign o_timer_cs = in_window(i_req.addr, bus_pkg::TIMER_BASE, bus_pkg::PERIPH_WORDS);
	assign o_irq_cs = in_window(i_req.addr, bus_pkg::IRQ_BASE, bus_pkg::PERIPH_WORDS);

	assign any_cs = o_ram_cs | o_timer_cs | o_irq_cs;

	// Unmapped access, ack so the master never hangs.
	always_ff @(posedge clk) begin
		if (i_rst) begin
			dflt_ack <= 1'b0;
			dflt_error <= 1'b0;
		end else begin
			dflt_ack <= i_access && !any_cs;
			dflt_error <= i_access && !any_cs;
		end
	end

	assign dflt_rsp = '{rdata: '0, ack: dflt_ack, error: dflt_error};

	assign o_rsp = i_ram_rsp | i_timer_rsp | i_irq_rsp | dflt_rsp;

endmodule

// File: source/bus_pkg.sv
// Shared types, address map and register offsets of the SoC data bus.
// All addresses here are word addresses, i.e. the byte address divided by four.
// Peripheral windows must stay aligned to PERIPH_WORDS so that the low
// address bits give the register offset directly.
package bus_pkg;

	localparam int NR_TIMERS = 2;
	localparam int NR_IRQS = 4;

	typedef logic [29:0] word_addr_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0] bytesel_t;
	typedef logic [NR_IRQS-1:0] irq_vec_t;

	// Valid only while the access strobe is high.
	typedef struct packed {
		word_addr_t addr;
		word_t wr_val;
		bytesel_t bytesel;
		logic wr_en;
	} bus_req_t;

	// All zeros from a responder that is not answering.
	typedef struct packed {
		word_t rdata;
		logic ack;
		logic error;
	} bus_rsp_t;

	localparam word_addr_t RAM_BASE = word_addr_t'(32'h2000_0000 >> 2);
	localparam int RAM_WORDS = 1024;
	localparam int RAM_AW = $clog2(RAM_WORDS);

	localparam word_addr_t IRQ_BASE = word_addr_t'(32'h8000_2000 >> 2);
	localparam word_addr_t TIMER_BASE = word_addr_t'(32'h8000_3000 >> 2);
	localparam int PERIPH_WORDS = 16;
	localparam int PERIPH_AW = $clog2(PERIPH_WORDS);

	typedef logic [PERIPH_AW-1:0] reg_off_t;

	// Timer n registers sit at these offsets plus n * TIMER_STRIDE.
	localparam reg_off_t TIMER_RELOAD = 4'd0;
	localparam reg_off_t TIMER_CONTROL = 4'd1;
	localparam reg_off_t TIMER_COUNT = 4'd2;
	localparam reg_off_t TIMER_EOI = 4'd3;
	localparam reg_off_t TIMER_STRIDE = 4'd4;

	localparam reg_off_t IRQ_STATUS = 4'd0;
	localparam reg_off_t IRQ_ENABLE = 4'd1;

	localparam int CTRL_ENABLE = 0;
	localparam int CTRL_PERIODIC = 1;
	localparam int CTRL_IRQ_EN = 2;
	localparam int CTRL_W = 3;

endpackage

// File: source/data_ram.sv
// Word-wide data RAM with byte-lane writes and a one-cycle response.
// Indexed by the low address bits only; the fabric does the window check.
// Contents are not reset. Read data is zero on write responses.
`timescale 1ns/10ps

module data_ram (
	input logic clk,
	input logic i_access,
	input logic i_cs,
	input bus_pkg::bus_req_t i_req,
	output bus_pkg::bus_rsp_t o_rsp
);

	localparam int NR_LANES = $bits(bus_pkg::bytesel_t);

	bus_pkg::word_t mem [bus_pkg::RAM_WORDS];
	logic [bus_pkg::RAM_AW-1:0] idx;
	logic sel;
	logic ack;
	bus_pkg::word_t rdata;

	assign idx = i_req.addr[bus_pkg::RAM_AW-1:0];
	assign sel = i_access && i_cs;

	// Only lanes with their byte select set are written.
	always_ff @(posedge clk) begin
		if (sel && i_req.wr_en) begin
			for (int b = 0; b < NR_LANES; b++) begin
				if (i_req.bytesel[b])
					mem[idx][b*8 +: 8] <= i_req.wr_val[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		rdata <= (sel && !i_req.wr_en) ? mem[idx] : '0;
		ack <= sel;
	end

	assign o_rsp = '{rdata: rdata, ack: ack, error: 1'b0};

endmodule

// File: source/irq_ctrl.sv
// Interrupt controller with an enable mask over level-sensitive lines.
// The request output is registered, one cycle behind the masked lines.
// Only ENABLE is writable; full-word writes, byte selects ignored.
`timescale 1ns/10ps

module irq_ctrl (
	input logic clk,
	input logic i_rst,
	input logic i_access,
	input logic i_cs,
	input bus_pkg::bus_req_t i_req,
	input bus_pkg::irq_vec_t i_irqs,
	output bus_pkg::bus_rsp_t o_rsp,
	output logic o_irq_req
);

	bus_pkg::irq_vec_t mask;
	bus_pkg::irq_vec_t pending;
	bus_pkg::reg_off_t off;
	logic wr;
	logic rd;
	bus_pkg::word_t rd_val;
	logic ack;
	bus_pkg::word_t rdata;

	assign off = i_req.addr[bus_pkg::PERIPH_AW-1:0];
	assign wr = i_access && i_cs && i_req.wr_en;
	assign rd = i_access && i_cs && !i_req.wr_en;

	assign pending = i_irqs & mask;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			mask <= '0;
			o_irq_req <= 1'b0;
		end else begin
			if (wr && off == bus_pkg::IRQ_ENABLE)
				mask <= i_req.wr_val[bus_pkg::NR_IRQS-1:0];
			o_irq_req <= |pending;
		end
	end

	always_comb begin
		case (off)
		bus_pkg::IRQ_STATUS: rd_val = bus_pkg::word_t'(pending);
		bus_pkg::IRQ_ENABLE: rd_val = bus_pkg::word_t'(mask);
		default: rd_val = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_rst)
			ack <= 1'b0;
		else
			ack <= i_access && i_cs;
	end

	// Zero on writes and when idle.
	always_ff @(posedge clk) begin
		rdata <= rd ? rd_val : '0;
	end

	assign o_rsp = '{rdata: rdata, ack: ack, error: 1'b0};

endmodule

// File: source/soc_bus_top.sv
// Data bus of the SoC: fabric, data RAM, timers and interrupt controller.
// Every access gets exactly one response, one cycle after its strobe.
// Interrupt lines 0 and 1 are the timers, 2 and 3 come from i_ext_irqs.
`timescale 1ns/10ps

module soc_bus_top (
	input logic clk,
	input logic i_rst,
	input logic i_access,
	input bus_pkg::bus_req_t i_req,
	input logic [bus_pkg::NR_IRQS-bus_pkg::NR_TIMERS-1:0] i_ext_irqs,
	output bus_pkg::bus_rsp_t o_rsp,
	output logic o_irq_req
);

	logic ram_cs;
	logic timer_cs;
	logic irq_cs;
	bus_pkg::bus_rsp_t ram_rsp;
	bus_pkg::bus_rsp_t timer_rsp;
	bus_pkg::bus_rsp_t irq_rsp;
	logic [bus_pkg::NR_TIMERS-1:0] timer_irqs;

	bus_fabric bus_fabric_i (
		.clk(clk),
		.i_rst(i_rst),
		.i_access(i_access),
		.i_req(i_req),
		.i_ram_rsp(ram_rsp),
		.i_timer_rsp(timer_rsp),
		.i_irq_rsp(irq_rsp),
		.o_ram_cs(ram_cs),
		.o_timer_cs(timer_cs),
		.o_irq_cs(irq_cs),
		.o_rsp(o_rsp)
	);

	data_ram data_ram_i (
		.clk(clk),
		.i_access(i_access),
		.i_cs(ram_cs),
		.i_req(i_req),
		.o_rsp(ram_rsp)
	);

	timer_block timer_block_i (
		.clk(clk),
		.i_rst(i_rst),
		.i_access(i_access),
		.i_cs(timer_cs),
		.i_req(i_req),
		.o_rsp(timer_rsp),
		.o_irqs(timer_irqs)
	);

	irq_ctrl irq_ctrl_i (
		.clk(clk),
		.i_rst(i_rst),
		.i_access(i_access),
		.i_cs(irq_cs),
		.i_req(i_req),
		.i_irqs({i_ext_irqs, timer_irqs}),
		.o_rsp(irq_rsp),
		.o_irq_req(o_irq_req)
	);

endmodule

// File: source/timer_block.sv
// Two down-counting timers with reload, one-shot or periodic mode.
// Registers take full-word writes; byte selects are ignored.
// COUNT is read-only. EOI reads back the flag in bit 0, a write clears it.
// Undefined offsets read zero and are acknowledged without error.
`timescale 1ns/10ps

module timer_block (
	input logic clk,
	input logic i_rst,
	input logic i_access,
	input logic i_cs,
	input bus_pkg::bus_req_t i_req,
	output bus_pkg::bus_rsp_t o_rsp,
	output logic [bus_pkg::NR_TIMERS-1:0] o_irqs
);

	localparam int CW = bus_pkg::CTRL_W;

	bus_pkg::word_t reload [bus_pkg::NR_TIMERS];
	bus_pkg::word_t count [bus_pkg::NR_TIMERS];
	logic [CW-1:0] ctrl [bus_pkg::NR_TIMERS];
	logic [bus_pkg::NR_TIMERS-1:0] flag;
	bus_pkg::reg_off_t off;
	logic wr;
	logic rd;
	bus_pkg::word_t rd_val;
	logic ack;
	bus_pkg::word_t rdata;

	// Register offset of a given timer.
	function automatic bus_pkg::reg_off_t treg(input bus_pkg::reg_off_t base, input int n);
		treg = bus_pkg::reg_off_t'(base + n * bus_pkg::TIMER_STRIDE);
	endfunction

	assign off = i_req.addr[bus_pkg::PERIPH_AW-1:0];
	assign wr = i_access && i_cs && i_req.wr_en;
	assign rd = i_access && i_cs && !i_req.wr_en;

	always_ff @(posedge clk) begin
		for (int i = 0; i < bus_pkg::NR_TIMERS; i++) begin
			if (wr && off == treg(bus_pkg::TIMER_RELOAD, i))
				reload[i] <= i_req.wr_val;
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			for (int i = 0; i < bus_pkg::NR_TIMERS; i++) begin
				ctrl[i] <= '0;
				count[i] <= '0;
			end
			flag <= '0;
		end else begin
			for (int i = 0; i < bus_pkg::NR_TIMERS; i++) begin
				// Cleared first so a new expiry in the same cycle wins.
				if (wr && off == treg(bus_pkg::TIMER_EOI, i))
					flag[i] <= 1'b0;

				if (ctrl[i][bus_pkg::CTRL_ENABLE]) begin
					if (count[i] == '0) begin
						flag[i] <= 1'b1;
						if (ctrl[i][bus_pkg::CTRL_PERIODIC])
							count[i] <= reload[i];
						else
							ctrl[i][bus_pkg::CTRL_ENABLE] <= 1'b0;
					end else begin
						count[i] <= count[i] - 1'b1;
					end
				end

				// Enabling restarts from the reload value.
				if (wr && off == treg(bus_pkg::TIMER_CONTROL, i)) begin
					ctrl[i] <= i_req.wr_val[CW-1:0];
					if (i_req.wr_val[bus_pkg::CTRL_ENABLE])
						count[i] <= reload[i];
				end
			end
		end
	end

	always_comb begin
		rd_val = '0;
		for (int i = 0; i < bus_pkg::NR_TIMERS; i++) begin
			if (off == treg(bus_pkg::TIMER_RELOAD, i))
				rd_val = reload[i];
			if (off == treg(bus_pkg::TIMER_CONTROL, i))
				rd_val = bus_pkg::word_t'(ctrl[i]);
			if (off == treg(bus_pkg::TIMER_COUNT, i))
				rd_val = count[i];
			if (off == treg(bus_pkg::TIMER_EOI, i))
				rd_val = bus_pkg::word_t'(flag[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst)
			ack <= 1'b0;
		else
			ack <= i_access && i_cs;
	end

	always_ff @(posedge clk) begin
		rdata <= rd ? rd_val : '0;
	end

	assign o_rsp = '{rdata: rdata, ack: ack, error: 1'b0};

	always_comb begin
		for (int i = 0; i < bus_pkg::NR_TIMERS; i++)
			o_irqs[i] = flag[i] & ctrl[i][bus_pkg::CTRL_IRQ_EN];
	end

endmodule

// File: verification/soc_bus_checker.sv
// Protocol and interrupt assertions for the SoC data bus, bound into soc_bus_top.
// Needs concurrent assertions enabled in the simulator.
// Every assertion latches its own flag, and any_failed is their OR.
`timescale 1ns/10ps

module soc_bus_checker (
	input logic clk,
	input logic i_rst,
	input logic i_access,
	input bus_pkg::bus_req_t i_req,
	input logic i_ram_cs,
	input logic i_timer_cs,
	input logic i_irq_cs,
	input bus_pkg::bus_rsp_t i_rsp,
	input bus_pkg::irq_vec_t i_pending,
	input logic i_irq_req
);

	logic any_cs;
	logic ack_missing = 1'b0;
	logic ack_spurious = 1'b0;
	logic error_wrong = 1'b0;
	logic error_missing = 1'b0;
	logic rdata_on_write = 1'b0;
	logic rdata_on_error = 1'b0;
	logic irq_wrong = 1'b0;
	logic any_failed;

	assign any_cs = i_ram_cs | i_timer_cs | i_irq_cs;
	assign any_failed = ack_missing | ack_spurious | error_wrong | error_missing |
		rdata_on_write | rdata_on_error | irq_wrong;

	ack_after_access: assert property (@(posedge clk) disable iff (i_rst)
		i_access |=> i_rsp.ack)
	else begin
		ack_missing = 1'b1;
		$error("Access without an ack in the next cycle.");
	end

	ack_needs_access: assert property (@(posedge clk) disable iff (i_rst)
		i_rsp.ack |-> $past(i_access))
	else begin
		ack_spurious = 1'b1;
		$error("Ack without an access in the cycle before.");
	end

	// Error is reserved for addresses outside every window.
	error_only_unmapped: assert property (@(posedge clk) disable iff (i_rst)
		i_rsp.error |-> $past(i_access && !any_cs))
	else begin
		error_wrong = 1'b1;
		$error("Error on an access that hit a window.");
	end

	unmapped_gets_error: assert property (@(posedge clk) disable iff (i_rst)
		i_access && !any_cs |=> i_rsp.error)
	else begin
		error_missing = 1'b1;
		$error("Unmapped access answered without error.");
	end

	write_rdata_zero: assert property (@(posedge clk) disable iff (i_rst)
		i_access && i_req.wr_en |=> i_rsp.rdata == '0)
	else begin
		rdata_on_write = 1'b1;
		$error("Nonzero read data on a write response.");
	end

	error_rdata_zero: assert property (@(posedge clk) disable iff (i_rst)
		i_rsp.error |-> i_rsp.rdata == '0)
	else begin
		rdata_on_error = 1'b1;
		$error("Nonzero read data on an error response.");
	end

	// Request is the OR of the masked lines, one cycle late.
	irq_follows_pending: assert property (@(posedge clk) disable iff (i_rst)
		i_irq_req == $past(|i_pending))
	else begin
		irq_wrong = 1'b1;
		$error("Interrupt request does not follow the masked lines.");
	end

endmodule

bind soc_bus_top soc_bus_checker soc_bus_checker_i (
	.clk(clk),
	.i_rst(i_rst),
	.i_access(i_access),
	.i_req(i_req),
	.i_ram_cs(ram_cs),
	.i_timer_cs(timer_cs),
	.i_irq_cs(irq_cs),
	.i_rsp(o_rsp),
	.i_pending(irq_ctrl_i.pending),
	.i_irq_req(o_irq_req)
);

// File: verification/soc_bus_tb.sv
// Testbench for the SoC data bus, acting as the processor at the top level.
// Responses are logged on the falling edge and compared in issue order.
// RAM reads only target words written earlier, since the RAM is not reset.
`timescale 1ns/10ps

module soc_bus_tb;

	localparam int TIMEOUT_CYCLES = 5000;
	localparam int NR_SLOTS = 16;
	localparam int NR_RAM_OPS = 64;
	localparam bus_pkg::word_t EN = 32'd1 << bus_pkg::CTRL_ENABLE;
	localparam bus_pkg::word_t PER = 32'd1 << bus_pkg::CTRL_PERIODIC;
	localparam bus_pkg::word_t IEN = 32'd1 << bus_pkg::CTRL_IRQ_EN;
	localparam bus_pkg::word_t RELOAD_1 = 32'd12;

	logic clk;
	logic i_rst;
	logic i_access;
	bus_pkg::bus_req_t i_req;
	logic [1:0] i_ext_irqs;
	bus_pkg::bus_rsp_t o_rsp;
	logic o_irq_req;

	int cycles = 0;
	int seed = 32'h34b0_c294;
	int rd_idx = 0;
	int slots [NR_SLOTS];
	bus_pkg::word_t ram_model [bus_pkg::RAM_WORDS];
	bus_pkg::bus_rsp_t rsp_log [$];
	bus_pkg::word_t exp_data_q [$];
	logic exp_err_q [$];
	logic exp_chk_q [$];

	soc_bus_top soc_bus_top_i (
		.clk(clk),
		.i_rst(i_rst),
		.i_access(i_access),
		.i_req(i_req),
		.i_ext_irqs(i_ext_irqs),
		.o_rsp(o_rsp),
		.o_irq_req(o_irq_req)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout, the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$fatal(1, "Simulation timed out.");
		end
	end

	always @(negedge clk) begin
		if (!i_rst && o_rsp.ack)
			rsp_log.push_back(o_rsp);
		if (soc_bus_top_i.soc_bus_checker_i.any_failed) begin
			$display("A bus protocol assertion failed.");
			$display("TESTS FAILED");
			$fatal(1, "Protocol check failed.");
		end
	end

	task automatic report_mismatch(input string sig, input bus_pkg::word_t exp,
		input bus_pkg::word_t act);
		$display("FAILED %s expected 0x%08h actual 0x%08h", sig, exp, act);
		$display("TESTS FAILED");
		$fatal(1, "Value mismatch.");
	endtask

	function automatic bus_pkg::word_t merge_bytes(input bus_pkg::word_t old_val,
		input bus_pkg::word_t new_val, input bus_pkg::bytesel_t bsel);
		bus_pkg::word_t lane_mask;
		lane_mask = {{8{bsel[3]}}, {8{bsel[2]}}, {8{bsel[1]}}, {8{bsel[0]}}};
		return (old_val & ~lane_mask) | (new_val & lane_mask);
	endfunction

	function automatic bus_pkg::word_addr_t ram_addr(input int idx);
		return bus_pkg::RAM_BASE + bus_pkg::word_addr_t'(idx);
	endfunction

	// Timer n registers repeat every four words.
	function automatic bus_pkg::word_addr_t timer_reg(input int n, input int off);
		return bus_pkg::TIMER_BASE + bus_pkg::word_addr_t'(off + 4 * n);
	endfunction

	function automatic bus_pkg::word_addr_t irq_reg(input int off);
		return bus_pkg::IRQ_BASE + bus_pkg::word_addr_t'(off);
	endfunction

	task automatic issue(input logic wr, input bus_pkg::word_addr_t addr,
		input bus_pkg::word_t data, input bus_pkg::bytesel_t bsel,
		input bus_pkg::word_t exp_data, input logic exp_err,
		input logic chk_data = 1'b1);
		@(posedge clk);
		i_access <= 1'b1;
		i_req <= '{addr: addr, wr_val: data, bytesel: bsel, wr_en: wr};
		exp_data_q.push_back(exp_data);
		exp_err_q.push_back(exp_err);
		exp_chk_q.push_back(chk_data);
	endtask

	// Idles the bus, then checks every outstanding response.
	task automatic drain(output bus_pkg::word_t last_data);
		bus_pkg::bus_rsp_t rsp;
		@(posedge clk);
		i_access <= 1'b0;
		i_req <= '0;
		last_data = '0;
		while (exp_data_q.size() > 0) begin
			while (rsp_log.size() <= rd_idx)
				@(posedge clk);
			rsp = rsp_log[rd_idx];
			rd_idx++;
			assert (rsp.error == exp_err_q[0])
			else report_mismatch("o_rsp.error", 32'(exp_err_q[0]), 32'(rsp.error));
			assert (!exp_chk_q[0] || rsp.rdata == exp_data_q[0])
			else report_mismatch("o_rsp.rdata", exp_data_q[0], rsp.rdata);
			last_data = rsp.rdata;
			void'(exp_data_q.pop_front());
			void'(exp_err_q.pop_front());
			void'(exp_chk_q.pop_front());
		end
	endtask

	task automatic write_word(input bus_pkg::word_addr_t addr, input bus_pkg::word_t data);
		bus_pkg::word_t unused;
		issue(1'b1, addr, data, 4'hf, '0, 1'b0);
		drain(unused);
	endtask

	// Read data is not compared here; the caller checks it.
	task automatic read_word(input bus_pkg::word_addr_t addr, output bus_pkg::word_t data);
		issue(1'b0, addr, '0, 4'hf, '0, 1'b0, 1'b0);
		drain(data);
	endtask

	task automatic wait_irq(input logic level);
		do
			@(negedge clk);
		while (o_irq_req != level);
	endtask

	task automatic ram_test();
		bus_pkg::word_t data;
		bus_pkg::bytesel_t bsel;
		int slot;
		for (int s = 0; s < NR_SLOTS; s++) begin
			slots[s] = (s == 0) ? 0 : $unsigned($random(seed)) % bus_pkg::RAM_WORDS;
			data = $random(seed);
			ram_model[slots[s]] = data;
			issue(1'b1, ram_addr(slots[s]), data, 4'hf, '0, 1'b0);
		end
		// Back-to-back mix of full writes, byte writes and reads.
		for (int k = 0; k < NR_RAM_OPS; k++) begin
			slot = slots[$unsigned($random(seed)) % NR_SLOTS];
			data = $random(seed);
			bsel = bus_pkg::bytesel_t'($random(seed));
			case ($unsigned($random(seed)) % 3)
			0: bsel = 4'hf;
			1: ;
			default: begin
				issue(1'b0, ram_addr(slot), '0, 4'hf, ram_model[slot], 1'b0);
				continue;
			end
			endcase
			ram_model[slot] = merge_bytes(ram_model[slot], data, bsel);
			issue(1'b1, ram_addr(slot), data, bsel, '0, 1'b0);
		end
		drain(data);
	endtask

	task automatic unmapped_test();
		bus_pkg::word_addr_t bad [6];
		bus_pkg::word_t data;
		bad[0] = bus_pkg::RAM_BASE + bus_pkg::word_addr_t'(bus_pkg::RAM_WORDS);
		bad[1] = bus_pkg::RAM_BASE - 30'd1;
		bad[2] = '0;
		bad[3] = bus_pkg::IRQ_BASE - 30'd1;
		bad[4] = bus_pkg::TIMER_BASE + bus_pkg::word_addr_t'(bus_pkg::PERIPH_WORDS);
		bad[5] = '1;
		for (int b = 0; b < 6; b++) begin
			issue(1'b1, bad[b], $random(seed), 4'hf, '0, 1'b1);
			issue(1'b0, bad[b], '0, 4'hf, '0, 1'b1);
		end
		// RAM must be untouched by the writes above.
		for (int s = 0; s < NR_SLOTS; s++)
			issue(1'b0, ram_addr(slots[s]), '0, 4'hf, ram_model[slots[s]], 1'b0);
		drain(data);
	endtask

	task automatic timer_test();
		bus_pkg::word_t data;
		write_word(timer_reg(0, 0), 32'd20);
		write_word(irq_reg(1), 32'h1);
		write_word(timer_reg(0, 1), EN | IEN);
		wait_irq(1'b1);
		read_word(timer_reg(0, 1), data);
		assert (data == IEN) else report_mismatch("timer0 control", IEN, data);
		write_word(timer_reg(0, 3), '0);
		@(negedge clk);
		assert (!o_irq_req) else report_mismatch("o_irq_req", '0, 32'(o_irq_req));
		// Timer 1 in periodic mode keeps coming back after each EOI.
		write_word(timer_reg(1, 0), RELOAD_1);
		write_word(irq_reg(1), 32'h2);
		write_word(timer_reg(1, 1), EN | PER | IEN);
		for (int k = 0; k < 2; k++) begin
			wait_irq(1'b1);
			read_word(timer_reg(1, 2), data);
			assert (data <= RELOAD_1) else report_mismatch("timer1 count", RELOAD_1, data);
			write_word(timer_reg(1, 3), '0);
			@(negedge clk);
			assert (!o_irq_req) else report_mismatch("o_irq_req", '0, 32'(o_irq_req));
		end
		wait_irq(1'b1);
		write_word(timer_reg(1, 1), '0);
		write_word(timer_reg(1, 3), '0);
		write_word(irq_reg(1), '0);
	endtask

	task automatic ext_irq_test();
		bus_pkg::word_t data;
		bus_pkg::irq_vec_t mask;
		bus_pkg::irq_vec_t status;
		for (int e = 0; e < 4; e++) begin
			@(posedge clk);
			i_ext_irqs <= 2'(e);
			for (int m = 0; m < 4; m++) begin
				mask = bus_pkg::irq_vec_t'(m << 2);
				status = {2'(e), 2'b00} & mask;
				write_word(irq_reg(1), 32'(mask));
				read_word(irq_reg(0), data);
				assert (data == 32'(status)) else report_mismatch("irq status", 32'(status), data);
				@(negedge clk);
				assert (o_irq_req == (status != '0))
				else report_mismatch("o_irq_req", 32'(status != '0), 32'(o_irq_req));
			end
		end
		write_word(irq_reg(1), '0);
		@(posedge clk);
		i_ext_irqs <= '0;
	endtask

	task automatic undefined_offset_test();
		bus_pkg::word_t data;
		for (int off = 8; off < bus_pkg::PERIPH_WORDS; off++) begin
			write_word(timer_reg(0, off), $random(seed));
			read_word(timer_reg(0, off), data);
			assert (data == '0) else report_mismatch("timer undefined reg", '0, data);
		end
		for (int off = 2; off < bus_pkg::PERIPH_WORDS; off++) begin
			write_word(irq_reg(off), $random(seed));
			read_word(irq_reg(off), data);
			assert (data == '0) else report_mismatch("irq undefined reg", '0, data);
		end
	endtask

	initial begin
		i_rst = 1'b1;
		i_access = 1'b0;
		i_req = '0;
		i_ext_irqs = '0;
		repeat (3) @(posedge clk);
		i_rst <= 1'b0;
		ram_test();
		unmapped_test();
		timer_test();
		ext_irq_test();
		undefined_offset_test();
		repeat (2) @(negedge clk);
		if (soc_bus_top_i.soc_bus_checker_i.any_failed || rsp_log.size() != rd_idx) begin
			$display("Unexpected responses or a failed assertion at the end of the run.");
			$display("TESTS FAILED");
			$fatal(1, "Run ended with errors.");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule
